// ==== hw/frame_writer_pkg.sv ====
`default_nettype none

// Shared definitions for the frame writer and its surroundings
package frame_writer_pkg;

   // ======================================================================
   // Memory request encodings
   // ======================================================================

   // Kind of request placed on the write channel
   typedef enum logic [1:0] {
      REQ_WR_LINE  = 2'd0,
      REQ_WR_FENCE = 2'd1
   } req_kind_t;

   // Cache-line address width of both channels
   localparam int ADDR_WIDTH = 32;

   // Width of one memory line and of one producer word
   localparam int LINE_WIDTH = 128;

   // Read tags let the writer pick its own responses out of the stream
   localparam int TAG_WIDTH = 4;
   localparam logic [TAG_WIDTH-1:0] TAG_HEADER = 4'h9;

   // ======================================================================
   // Frame geometry
   // ======================================================================

   // Eight frames in the ring, eight chunks per frame
   localparam int LOG_FRAME_NUMBER = 3;
   localparam int LOG_FRAME_CHUNKS = 3;

   // Marker in the top bits of a control line, so software can tell it apart
   localparam logic [15:0] CTRL_MARK = 16'hC0DE;

   // Producer silence in cycles before a partly filled frame is closed
   localparam int IDLE_LIMIT = 15;

endpackage

`default_nettype wire

// ==== hw/line_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

// Circular buffer with a generic payload
// The head entry is shown combinationally, so a pop takes effect at the next edge
module line_fifo #(
   parameter type line_t = logic [127:0],
   parameter int  DEPTH  = 16
) (
   input  wire logic  clk,
   input  wire logic  rst_n,
   input  wire logic  push,
   input  wire line_t push_data,
   input  wire logic  pop,
   output line_t      pop_data,
   output logic       not_empty,
   output logic       not_full
);

   // A depth of one still needs a one-bit pointer
   localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_WIDTH = $clog2(DEPTH + 1);

   localparam logic [PTR_WIDTH-1:0] LAST_SLOT = PTR_WIDTH'(DEPTH - 1);
   localparam logic [CNT_WIDTH-1:0] FULL_CNT  = CNT_WIDTH'(DEPTH);

   line_t                mem [DEPTH];
   logic [PTR_WIDTH-1:0] wr_ptr;
   logic [PTR_WIDTH-1:0] rd_ptr;
   logic [CNT_WIDTH-1:0] count;

   logic do_push;
   logic do_pop;

   // Requests against a full or empty buffer are ignored here
   assign do_push = push && not_full;
   assign do_pop  = pop && not_empty;

   assign not_empty = (count != '0);
   assign not_full  = (count != FULL_CNT);
   assign pop_data  = mem[rd_ptr];

   // Storage has no reset, only the pointers and the count do
   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= push_data;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         // Pointers wrap by compare, so DEPTH need not be a power of two
         if (do_push) begin
            wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
         end
         // A push and a pop in one cycle leave the count alone
         if (do_push && !do_pop) begin
            count <= count + 1'b1;
         end else if (do_pop && !do_push) begin
            count <= count - 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== hw/frame_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

// Fills frames of a host-memory ring with producer data
module frame_writer #(
   parameter int LOG_FRAME_NUMBER = frame_writer_pkg::LOG_FRAME_NUMBER,
   parameter int LOG_FRAME_CHUNKS = frame_writer_pkg::LOG_FRAME_CHUNKS,
   parameter int IDLE_LIMIT       = frame_writer_pkg::IDLE_LIMIT,
   parameter int BUFFER_DEPTH     = 16
) (
   input  wire logic                                    clk,
   input  wire logic                                    rst_n,
   input  wire logic                                    afu_en,
   input  wire logic [frame_writer_pkg::ADDR_WIDTH-LOG_FRAME_NUMBER-LOG_FRAME_CHUNKS-1:0]
                                                        frame_base,
   // Producer side
   input  wire logic [frame_writer_pkg::LINE_WIDTH-1:0] tx_data,
   input  wire logic                                    tx_enable,
   output logic                                         tx_not_full,
   // Read channel
   output logic                                         rd_req,
   output logic [frame_writer_pkg::ADDR_WIDTH-1:0]      rd_addr,
   output logic [frame_writer_pkg::TAG_WIDTH-1:0]       rd_tag,
   input  wire logic                                    rd_grant,
   // Read response
   input  wire logic                                    rsp_valid,
   input  wire logic [frame_writer_pkg::TAG_WIDTH-1:0]  rsp_tag,
   input  wire logic [frame_writer_pkg::LINE_WIDTH-1:0] rsp_data,
   // Write channel
   output logic                                         wr_req,
   output frame_writer_pkg::req_kind_t                  wr_kind,
   output logic [frame_writer_pkg::ADDR_WIDTH-1:0]      wr_addr,
   output logic [frame_writer_pkg::LINE_WIDTH-1:0]      wr_data,
   input  wire logic                                    wr_grant
);

   import frame_writer_pkg::*;

   localparam int IDLE_WIDTH = $clog2(IDLE_LIMIT + 1);

   localparam logic [IDLE_WIDTH-1:0]       IDLE_MAX    = IDLE_WIDTH'(IDLE_LIMIT);
   localparam logic [LOG_FRAME_CHUNKS-1:0] LAST_CHUNK  = '1;
   localparam logic [LOG_FRAME_CHUNKS-1:0] FIRST_CHUNK = LOG_FRAME_CHUNKS'(1);
   localparam logic [LOG_FRAME_CHUNKS-1:0] CTRL_CHUNK  = '0;

   // ======================================================================
   // Frame control FSM
   // ======================================================================

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_POLL_HEADER,
      ST_WAIT_HEADER,
      ST_WRITE,
      ST_WRITE_FENCE,
      ST_WRITE_CONTROL
   } state_t;

   state_t state;
   state_t next_state;

   logic [LOG_FRAME_NUMBER-1:0] frame_number;
   logic [LOG_FRAME_CHUNKS-1:0] frame_chunk;
   logic [LOG_FRAME_CHUNKS-1:0] chunks_written;
   logic [IDLE_WIDTH-1:0]       idle_count;

   logic                  buf_not_empty;
   logic [LINE_WIDTH-1:0] buf_head;
   logic                  header_rsp;
   logic                  header_free;
   logic                  data_accept;
   logic                  idle_close;
   logic [LINE_WIDTH-1:0] ctrl_line;

   // Only tagged header responses matter and everything else belongs to others
   assign header_rsp  = rsp_valid && (rsp_tag == TAG_HEADER);
   // Software clears bit 0 once it has drained the frame
   assign header_free = !rsp_data[0];

   // A word leaves the buffer only with a data write that was really requested
   assign data_accept = (state == ST_WRITE) && wr_req && wr_grant;

   // Close on silence only with data in the frame and nothing waiting to go
   assign idle_close = (idle_count == IDLE_MAX) && (frame_chunk != FIRST_CHUNK)
                       && !buf_not_empty;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= ST_IDLE;
      end else if (!afu_en) begin
         state <= ST_IDLE;
      end else begin
         state <= next_state;
      end
   end

   always_comb begin
      next_state = state;
      case (state)
         ST_IDLE: begin
            next_state = ST_POLL_HEADER;
         end
         ST_POLL_HEADER: begin
            if (rd_grant) begin
               next_state = ST_WAIT_HEADER;
            end
         end
         ST_WAIT_HEADER: begin
            // A busy frame sends us back to poll it again
            if (header_rsp) begin
               next_state = header_free ? ST_WRITE : ST_POLL_HEADER;
            end
         end
         ST_WRITE: begin
            if ((data_accept && frame_chunk == LAST_CHUNK) || idle_close) begin
               next_state = ST_WRITE_FENCE;
            end
         end
         ST_WRITE_FENCE: begin
            if (wr_grant) begin
               next_state = ST_WRITE_CONTROL;
            end
         end
         ST_WRITE_CONTROL: begin
            if (wr_grant) begin
               next_state = ST_POLL_HEADER;
            end
         end
         default: begin
            next_state = ST_IDLE;
         end
      endcase
   end

   // ======================================================================
   // Frame number, chunk index and idle counter
   // ======================================================================

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         frame_number <= '0;
         frame_chunk  <= FIRST_CHUNK;
         idle_count   <= '0;
      end else begin
         // Disabling the writer restarts the ring at frame 0
         if (!afu_en || state == ST_IDLE) begin
            frame_number <= '0;
         end else if (state == ST_WRITE_CONTROL && wr_grant) begin
            frame_number <= frame_number + 1'b1;
         end

         // Data starts one past the header chunk
         // After the last chunk the index wraps to 0, which still gives the right count
         if (state == ST_POLL_HEADER) begin
            frame_chunk <= FIRST_CHUNK;
         end else if (data_accept) begin
            frame_chunk <= frame_chunk + 1'b1;
         end

         // Counts empty-buffer cycles in the data phase and saturates at the limit
         if (state != ST_WRITE || buf_not_empty) begin
            idle_count <= '0;
         end else if (idle_count != IDLE_MAX) begin
            idle_count <= idle_count + 1'b1;
         end
      end
   end

   // ======================================================================
   // Request formation
   // ======================================================================

   assign chunks_written = frame_chunk - FIRST_CHUNK;

   // Control line is marker on top, chunk count from bit 8, valid in bit 0
   always_comb begin
      ctrl_line = '0;
      ctrl_line[LINE_WIDTH-1 -: $bits(CTRL_MARK)] = CTRL_MARK;
      ctrl_line[8 +: LOG_FRAME_CHUNKS] = chunks_written;
      ctrl_line[0] = 1'b1;
   end

   // Header polls always target chunk 0 of the current frame
   assign rd_req  = afu_en && (state == ST_POLL_HEADER);
   assign rd_addr = {frame_base, frame_number, CTRL_CHUNK};
   assign rd_tag  = TAG_HEADER;

   assign wr_req = afu_en && (((state == ST_WRITE) && buf_not_empty)
                              || (state == ST_WRITE_FENCE)
                              || (state == ST_WRITE_CONTROL));

   always_comb begin
      wr_kind = REQ_WR_LINE;
      wr_addr = {frame_base, frame_number, CTRL_CHUNK};
      wr_data = '0;
      case (state)
         ST_WRITE: begin
            wr_addr = {frame_base, frame_number, frame_chunk};
            wr_data = buf_head;
         end
         ST_WRITE_FENCE: begin
            wr_kind = REQ_WR_FENCE;
         end
         ST_WRITE_CONTROL: begin
            wr_data = ctrl_line;
         end
         default: begin
            wr_kind = REQ_WR_LINE;
         end
      endcase
   end

   // ======================================================================
   // Producer data buffer
   // ======================================================================

   // The head is popped only when its write is accepted
   line_fifo #(
      .line_t (logic [LINE_WIDTH-1:0]),
      .DEPTH  (BUFFER_DEPTH)
   ) u_data_buf (
      .clk       (clk),
      .rst_n     (rst_n),
      .push      (tx_enable),
      .push_data (tx_data),
      .pop       (data_accept),
      .pop_data  (buf_head),
      .not_empty (buf_not_empty),
      .not_full  (tx_not_full)
   );

endmodule

`default_nettype wire

// ==== hw/frame_writer_top.sv ====
`timescale 1ns/1ps
`default_nettype none

// Top level of the frame writer subsystem
// Ring geometry and idle limit come from the shared package
module frame_writer_top (
   input  wire logic                                    clk,
   input  wire logic                                    rst_n,
   input  wire logic                                    afu_en,
   input  wire logic [frame_writer_pkg::ADDR_WIDTH-frame_writer_pkg::LOG_FRAME_NUMBER
                      -frame_writer_pkg::LOG_FRAME_CHUNKS-1:0]
                                                        frame_base,
   // Producer side
   input  wire logic [frame_writer_pkg::LINE_WIDTH-1:0] tx_data,
   input  wire logic                                    tx_enable,
   output logic                                         tx_not_full,
   // Read channel and its responses
   output logic                                         rd_req,
   output logic [frame_writer_pkg::ADDR_WIDTH-1:0]      rd_addr,
   output logic [frame_writer_pkg::TAG_WIDTH-1:0]       rd_tag,
   input  wire logic                                    rd_grant,
   input  wire logic                                    rsp_valid,
   input  wire logic [frame_writer_pkg::TAG_WIDTH-1:0]  rsp_tag,
   input  wire logic [frame_writer_pkg::LINE_WIDTH-1:0] rsp_data,
   // Write channel
   output logic                                         wr_req,
   output frame_writer_pkg::req_kind_t                  wr_kind,
   output logic [frame_writer_pkg::ADDR_WIDTH-1:0]      wr_addr,
   output logic [frame_writer_pkg::LINE_WIDTH-1:0]      wr_data,
   input  wire logic                                    wr_grant
);

   import frame_writer_pkg::*;

   // Sixteen lines of buffering ride out short grant stalls
   localparam int BUFFER_DEPTH = 16;

   frame_writer #(
      .LOG_FRAME_NUMBER (LOG_FRAME_NUMBER),
      .LOG_FRAME_CHUNKS (LOG_FRAME_CHUNKS),
      .IDLE_LIMIT       (IDLE_LIMIT),
      .BUFFER_DEPTH     (BUFFER_DEPTH)
   ) u_frame_writer (
      .clk         (clk),
      .rst_n       (rst_n),
      .afu_en      (afu_en),
      .frame_base  (frame_base),
      .tx_data     (tx_data),
      .tx_enable   (tx_enable),
      .tx_not_full (tx_not_full),
      .rd_req      (rd_req),
      .rd_addr     (rd_addr),
      .rd_tag      (rd_tag),
      .rd_grant    (rd_grant),
      .rsp_valid   (rsp_valid),
      .rsp_tag     (rsp_tag),
      .rsp_data    (rsp_data),
      .wr_req      (wr_req),
      .wr_kind     (wr_kind),
      .wr_addr     (wr_addr),
      .wr_data     (wr_data),
      .wr_grant    (wr_grant)
   );

endmodule

`default_nettype wire

// ==== verification/frame_writer_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

// Protocol properties of the frame writer channels
module frame_writer_assertions (
   input wire logic                                    clk,
   input wire logic                                    rst_n,
   input wire logic                                    afu_en,
   input wire logic                                    tx_enable,
   input wire logic                                    tx_not_full,
   input wire logic                                    rd_req,
   input wire logic                                    rd_grant,
   input wire logic [frame_writer_pkg::ADDR_WIDTH-1:0] rd_addr,
   input wire logic                                    wr_req,
   input wire logic                                    wr_grant,
   input wire logic [1:0]                              wr_kind,
   input wire logic [frame_writer_pkg::ADDR_WIDTH-1:0] wr_addr,
   input wire logic [frame_writer_pkg::LINE_WIDTH-1:0] wr_data
);

   // The writer never asks both channels in one cycle
   one_channel: assert property (@(posedge clk) disable iff (!rst_n) !(rd_req && wr_req))
      else $error("read and write requests raised together");

   // A waiting request keeps its contents until granted, unless the writer is disabled
   rd_hold: assert property (@(posedge clk) disable iff (!rst_n)
      rd_req && !rd_grant |=> !afu_en || (rd_req && $stable(rd_addr)))
      else $error("held read request changed before its grant");

   wr_hold: assert property (@(posedge clk) disable iff (!rst_n)
      wr_req && !wr_grant |=> !afu_en || (wr_req && $stable(wr_addr)
                                          && $stable(wr_data) && $stable(wr_kind)))
      else $error("held write request changed before its grant");

   // The producer must respect the buffer level
   no_overflow: assert property (@(posedge clk) disable iff (!rst_n) !(tx_enable && !tx_not_full))
      else $error("producer pushed into a full buffer");

endmodule

bind frame_writer frame_writer_assertions u_assertions (
   .clk         (clk),
   .rst_n       (rst_n),
   .afu_en      (afu_en),
   .tx_enable   (tx_enable),
   .tx_not_full (tx_not_full),
   .rd_req      (rd_req),
   .rd_grant    (rd_grant),
   .rd_addr     (rd_addr),
   .wr_req      (wr_req),
   .wr_grant    (wr_grant),
   .wr_kind     (wr_kind),
   .wr_addr     (wr_addr),
   .wr_data     (wr_data)
);

`default_nettype wire

// ==== verification/frame_writer_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_writer_tb;

   import frame_writer_pkg::*;

   localparam int SEED       = 88;
   localparam int NUM_WORDS  = 600;
   localparam int MAX_CYCLES = 40 * NUM_WORDS + 2000;
   localparam int BUF_DEPTH  = 16;
   localparam int BASE_WIDTH = ADDR_WIDTH - LOG_FRAME_NUMBER - LOG_FRAME_CHUNKS;
   localparam logic [BASE_WIDTH-1:0] BASE = 26'h2A5F3C1;

   // Model phases of the writer as seen from the channels
   localparam int PH_POLL = 0;
   localparam int PH_WAIT = 1;
   localparam int PH_DATA = 2;
   localparam int PH_CTRL = 3;

   logic                  clk;
   logic                  rst_n;
   logic                  afu_en;
   logic [BASE_WIDTH-1:0] frame_base;
   logic [LINE_WIDTH-1:0] tx_data;
   logic                  tx_enable;
   logic                  tx_not_full;
   logic                  rd_req;
   logic [ADDR_WIDTH-1:0] rd_addr;
   logic [TAG_WIDTH-1:0]  rd_tag;
   logic                  rd_grant;
   logic                  rsp_valid;
   logic [TAG_WIDTH-1:0]  rsp_tag;
   logic [LINE_WIDTH-1:0] rsp_data;
   logic                  wr_req;
   req_kind_t             wr_kind;
   logic [ADDR_WIDTH-1:0] wr_addr;
   logic [LINE_WIDTH-1:0] wr_data;
   logic                  wr_grant;

   // Reference model state
   logic [LINE_WIDTH-1:0]       word_q [$];
   int                          phase;
   logic [LOG_FRAME_NUMBER-1:0] exp_frame;
   logic [LOG_FRAME_CHUNKS-1:0] exp_chunk;
   int                          empty_cycles;
   bit                          idle_due;
   int                          words_sent;
   int                          words_written;
   int                          frames_closed;
   int                          cycles;

   // Memory and producer stimulus state
   bit rsp_pending;
   int rsp_wait;
   bit in_burst;
   int mode_left;
   int toggle_left;
   bit toggled;

   frame_writer_top u_dut (
      .clk         (clk),
      .rst_n       (rst_n),
      .afu_en      (afu_en),
      .frame_base  (frame_base),
      .tx_data     (tx_data),
      .tx_enable   (tx_enable),
      .tx_not_full (tx_not_full),
      .rd_req      (rd_req),
      .rd_addr     (rd_addr),
      .rd_tag      (rd_tag),
      .rd_grant    (rd_grant),
      .rsp_valid   (rsp_valid),
      .rsp_tag     (rsp_tag),
      .rsp_data    (rsp_data),
      .wr_req      (wr_req),
      .wr_kind     (wr_kind),
      .wr_addr     (wr_addr),
      .wr_data     (wr_data),
      .wr_grant    (wr_grant)
   );

   always #10 clk = ~clk;

   // ======================================================================
   // Expected values
   // ======================================================================

   // Base pointer on top, then frame number, then chunk index
   function automatic logic [ADDR_WIDTH-1:0] line_addr(input logic [LOG_FRAME_NUMBER-1:0] frame,
                                                       input logic [LOG_FRAME_CHUNKS-1:0] chunk);
      return {BASE, frame, chunk};
   endfunction

   // Marker in the top 16 bits, data chunk count from bit 8, bit 0 set
   function automatic logic [LINE_WIDTH-1:0] control_line(
      input logic [LOG_FRAME_CHUNKS-1:0] count
   );
      return {CTRL_MARK, {(LINE_WIDTH-16-8-LOG_FRAME_CHUNKS){1'b0}}, count, 7'b0, 1'b1};
   endfunction

   task automatic check_value(input string name, input logic [LINE_WIDTH-1:0] actual,
                              input logic [LINE_WIDTH-1:0] expected);
      if (actual !== expected) begin
         $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
         $display("Checks failed");
         $fatal(1, "stopping at the first mismatch");
      end
   endtask

   task automatic stop_with_error(input string what);
      $display("ERROR at %0t ns: %s", $time, what);
      $display("Checks failed");
      $fatal(1, "stopping at the first error");
   endtask

   // ======================================================================
   // Monitor, run at each rising edge before new stimulus
   // ======================================================================

   task automatic accept_write();
      case (phase)
         PH_DATA: begin
            if (wr_kind == REQ_WR_FENCE) begin
               // A close is due after the last chunk or after a silent spell
               if (exp_chunk != 0 && !idle_due) stop_with_error("frame closed too early");
               phase = PH_CTRL;
            end else begin
               if (exp_chunk == 0) stop_with_error("data written past the last chunk");
               if (idle_due) stop_with_error("idle limit passed without closing the frame");
               if (word_q.size() == 0) stop_with_error("data write without a queued word");
               check_value("wr_addr", wr_addr, line_addr(exp_frame, exp_chunk));
               check_value("wr_data", wr_data, word_q.pop_front());
               exp_chunk++;
               words_written++;
            end
         end
         PH_CTRL: begin
            // The chunk index has moved one past the last data chunk
            check_value("wr_kind", wr_kind, REQ_WR_LINE);
            check_value("wr_addr", wr_addr, line_addr(exp_frame, '0));
            check_value("wr_data", wr_data, control_line(exp_chunk - 1'b1));
            exp_frame++;
            frames_closed++;
            phase = PH_POLL;
         end
         default: stop_with_error("write accepted while the header was being polled");
      endcase
   endtask

   task automatic observe_edge();
      if (rd_req && wr_req) stop_with_error("read and write requested in the same cycle");
      // The buffer takes a word while it holds fewer words than its depth
      check_value("tx_not_full", tx_not_full, word_q.size() < BUF_DEPTH);
      if (!afu_en) begin
         // A disabled writer requests nothing and restarts the ring at frame 0
         check_value("rd_req", rd_req, 1'b0);
         check_value("wr_req", wr_req, 1'b0);
         phase        = PH_POLL;
         exp_frame    = '0;
         exp_chunk    = 1;
         empty_cycles = 0;
         idle_due     = 1'b0;
         rsp_pending  = 1'b0;
      end else begin
         // Silent cycles in the data phase, counted on the buffer state before this edge
         if (phase == PH_DATA && word_q.size() == 0) begin
            empty_cycles++;
            if (empty_cycles > IDLE_LIMIT && exp_chunk != 1) idle_due = 1'b1;
         end else begin
            empty_cycles = 0;
         end
         if (rsp_valid && rsp_tag == TAG_HEADER) begin
            if (phase != PH_WAIT) stop_with_error("header response with no read outstanding");
            if (rsp_data[0]) begin
               phase = PH_POLL;
            end else begin
               phase        = PH_DATA;
               exp_chunk    = 1;
               empty_cycles = 0;
               idle_due     = 1'b0;
            end
         end
         if (rd_req && rd_grant) begin
            if (phase != PH_POLL) stop_with_error("header read issued outside of polling");
            check_value("rd_addr", rd_addr, line_addr(exp_frame, '0));
            check_value("rd_tag", rd_tag, TAG_HEADER);
            phase       = PH_WAIT;
            rsp_pending = 1'b1;
            rsp_wait    = $urandom_range(1, 4);
         end
         if (wr_req && wr_grant) accept_write();
      end
      // The buffer takes words whether the writer is enabled or not
      if (tx_enable && tx_not_full) begin
         word_q.push_back(tx_data);
         words_sent++;
      end
   endtask

   // ======================================================================
   // Stimulus, driven 1 ns after the edge
   // ======================================================================

   task automatic drive_stimulus();
      logic [TAG_WIDTH-1:0] stray;
      // Bursts of up to 12 cycles, gaps long enough for idle closes
      if (mode_left == 0) begin
         in_burst  = !in_burst;
         mode_left = in_burst ? $urandom_range(1, 12) : $urandom_range(1, 40);
      end
      mode_left--;
      tx_enable = in_burst && ($urandom_range(0, 3) != 0) && tx_not_full
                  && (words_sent < NUM_WORDS);
      tx_data   = {$urandom, $urandom, $urandom, $urandom};
      rd_grant  = ($urandom_range(0, 2) != 0);
      wr_grant  = ($urandom_range(0, 3) != 0);

      // Header responses come 1 to 4 cycles after the read, one in four busy
      rsp_valid = 1'b0;
      rsp_tag   = '0;
      rsp_data  = {$urandom, $urandom, $urandom, $urandom};
      if (rsp_pending) begin
         rsp_wait--;
         if (rsp_wait == 0) begin
            rsp_pending = 1'b0;
            rsp_valid   = 1'b1;
            rsp_tag     = TAG_HEADER;
            rsp_data[0] = ($urandom_range(0, 3) == 0);
         end
      end
      // Responses meant for other readers share the bus
      if (!rsp_valid && $urandom_range(0, 7) == 0) begin
         stray = TAG_WIDTH'($urandom_range(0, 15));
         if (stray == TAG_HEADER) stray = stray ^ 4'h1;
         rsp_valid = 1'b1;
         rsp_tag   = stray;
      end

      // One short disable pulse half way through the stream
      if (!toggled && words_sent >= NUM_WORDS / 2) begin
         toggled     = 1'b1;
         toggle_left = 4;
      end
      if (toggle_left > 0) toggle_left--;
      afu_en = (cycles >= 4) && (toggle_left == 0);
   endtask

   initial begin
      void'($urandom(SEED));
      clk        = 1'b0;
      rst_n      = 1'b0;
      afu_en     = 1'b0;
      frame_base = BASE;
      tx_data    = '0;
      tx_enable  = 1'b0;
      rd_grant   = 1'b0;
      rsp_valid  = 1'b0;
      rsp_tag    = '0;
      rsp_data   = '0;
      wr_grant   = 1'b0;
      phase      = PH_POLL;
      exp_frame  = '0;
      exp_chunk  = 1;
      repeat (5) @(posedge clk);
      #1 rst_n = 1'b1;

      // Run until every word is written and the last frame is closed
      while (!(words_sent == NUM_WORDS && words_written == NUM_WORDS && phase == PH_POLL)) begin
         @(posedge clk);
         observe_edge();
         cycles++;
         if (cycles >= MAX_CYCLES) stop_with_error("timed out before all words were written");
         #1;
         drive_stimulus();
      end

      $display("All checks passed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== frame_writer_top.f ====
hw/frame_writer_pkg.sv
hw/line_fifo.sv
hw/frame_writer.sv
hw/frame_writer_top.sv
verification/frame_writer_assertions.sv
verification/frame_writer_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -j 0 \
   --top-module frame_writer_tb -f frame_writer_top.f

obj_dir/Vframe_writer_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "All checks passed" sim.log; then
   echo "Simulation result: PASS"
else
   echo "Simulation result: FAIL"
   exit 1
fi
